// File: rtl/len_fifo.sv
/* Packet length FIFO */

`timescale 1ns/1ps

module len_fifo import pkt_ex_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic  phys_port_clk_ifc,
    input  logic  rst_n,
    input  logic  push,
    input  blen_t push_len,
    input  logic  pop,
    output blen_t head_len,
    output logic  full,
    output logic  empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    blen_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic wr_en;
    logic rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign head_len = mem[rd_ptr];

    always_ff @(posedge phys_port_clk_ifc) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_len;
        end
    end

    // Pointers wrap at any depth, not only powers of two
    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: rtl/pkt_chk.sv
/* Per-port receive checker */

`timescale 1ns/1ps

module pkt_chk import pkt_ex_pkg::*; (
    input  logic  phys_port_clk_ifc,
    input  logic  rst_n,

    // Receive stream, always accepted
    input  beat_t rx_beat,
    input  logic  rx_valid,

    // Length FIFO read side
    input  blen_t head_len,
    input  logic  empty,
    output logic  pop,

    input  logic  clear,
    output cnt_t  rx_frame_cnt,
    output cnt_t  rx_err_cnt
);

    localparam int NB_W = $clog2(BYTES_PER_WORD + 1);

    // Byte index of the next expected byte
    blen_t idx;
    logic  err_seen;

    logic            beat_err;
    logic [NB_W-1:0] nbytes;
    blen_t           total;
    logic            pkt_bad;
    logic            done;

    //////////////////////////////
    // Beat check

    always_comb begin
        logic [7:0] exp_byte;

        beat_err = 1'b0;

        // Only contiguous keep from byte 0 is legal
        case (rx_beat.keep)
            4'b0001: nbytes = NB_W'(1);
            4'b0011: nbytes = NB_W'(2);
            4'b0111: nbytes = NB_W'(3);
            4'b1111: nbytes = NB_W'(4);
            default: begin
                nbytes   = '0;
                beat_err = 1'b1;
            end
        endcase

        if (!rx_beat.last && rx_beat.keep != '1) begin
            beat_err = 1'b1;
        end

        for (int k = 0; k < BYTES_PER_WORD; k++) begin
            exp_byte = idx[7:0] + 8'(k);
            if (rx_beat.keep[k] && rx_beat.data[8*k +: 8] != exp_byte) begin
                beat_err = 1'b1;
            end
        end

        total   = idx + blen_t'(nbytes);
        pkt_bad = err_seen || beat_err || empty || (total != head_len);
    end

    assign done = rx_valid && rx_beat.last;

    // A missing length counts as an error and leaves the FIFO alone
    assign pop = done && !empty;

    //////////////////////////////
    // Packet tracking

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            idx      <= '0;
            err_seen <= 1'b0;
        end else if (rx_valid) begin
            if (rx_beat.last) begin
                idx      <= '0;
                err_seen <= 1'b0;
            end else begin
                idx      <= total;
                err_seen <= err_seen || beat_err;
            end
        end
    end

    //////////////////////////////
    // Counters

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            rx_frame_cnt <= '0;
            rx_err_cnt   <= '0;
        end else if (clear) begin
            rx_frame_cnt <= '0;
            rx_err_cnt   <= '0;
        end else if (done) begin
            if (pkt_bad) begin
                rx_err_cnt <= rx_err_cnt + 1'b1;
            end else begin
                rx_frame_cnt <= rx_frame_cnt + 1'b1;
            end
        end
    end

endmodule

// File: rtl/pkt_ex_pkg.sv
/* Packet exerciser shared types */

package pkt_ex_pkg;

    //////////////////////////////
    // Sizes

    // Bytes carried by one stream word
    localparam int BYTES_PER_WORD = 4;

    // Largest packet in bytes
    localparam int MTU_BYTES = 1500;

    localparam int DATA_WIDTH = 8 * BYTES_PER_WORD;
    localparam int BLEN_WIDTH = $clog2(MTU_BYTES + 1);
    localparam int CNT_WIDTH  = 32;

    //////////////////////////////
    // Vector types

    // One stream word, byte 0 in bits 7..0
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Byte enables, bit k marks byte k
    typedef logic [BYTES_PER_WORD-1:0] keep_t;

    // Packet length in bytes
    typedef logic [BLEN_WIDTH-1:0] blen_t;

    // Frame and error counters
    typedef logic [CNT_WIDTH-1:0] cnt_t;

    //////////////////////////////
    // Stream beat

    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
    } beat_t;

    //////////////////////////////
    // Generator FSM

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        DONE
    } gen_state_t;

endpackage

// File: rtl/pkt_exerciser_top.sv
/* Packet exerciser top */

`timescale 1ns/1ps

module pkt_exerciser_top import pkt_ex_pkg::*; #(
    parameter int NUM_PORTS  = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 phys_port_clk_ifc,
    input  logic                 rst_n,

    // Request side
    input  logic [NUM_PORTS-1:0] req,
    input  blen_t                len [NUM_PORTS],
    output logic [NUM_PORTS-1:0] ack,

    // Transmit streams
    output beat_t                tx_beat [NUM_PORTS],
    output logic [NUM_PORTS-1:0] tx_valid,
    input  logic [NUM_PORTS-1:0] tx_ready,

    // Returned streams
    input  beat_t                rx_beat [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] rx_valid,

    // Counters
    input  logic [NUM_PORTS-1:0] enable,
    input  logic [NUM_PORTS-1:0] clear,
    output cnt_t                 tx_frame_cnt [NUM_PORTS],
    output cnt_t                 rx_frame_cnt [NUM_PORTS],
    output cnt_t                 rx_err_cnt [NUM_PORTS]
);

    //////////////////////////////
    // Ports

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port

        logic  push;
        blen_t push_len;
        logic  full;
        logic  pop;
        blen_t head_len;
        logic  empty;

        pkt_gen i_pkt_gen (
            .phys_port_clk_ifc ( phys_port_clk_ifc ),
            .rst_n             ( rst_n             ),
            .req               ( req[p]            ),
            .len               ( len[p]            ),
            .ack               ( ack[p]            ),
            .tx_beat           ( tx_beat[p]        ),
            .tx_valid          ( tx_valid[p]       ),
            .tx_ready          ( tx_ready[p]       ),
            .push              ( push              ),
            .push_len          ( push_len          ),
            .full              ( full              ),
            .enable            ( enable[p]         ),
            .clear             ( clear[p]          ),
            .tx_frame_cnt      ( tx_frame_cnt[p]   )
        );

        // Lengths of packets in flight between generator and checker
        len_fifo #(
            .FIFO_DEPTH ( FIFO_DEPTH )
        ) i_len_fifo (
            .phys_port_clk_ifc ( phys_port_clk_ifc ),
            .rst_n             ( rst_n             ),
            .push              ( push              ),
            .push_len          ( push_len          ),
            .pop               ( pop               ),
            .head_len          ( head_len          ),
            .full              ( full              ),
            .empty             ( empty             )
        );

        pkt_chk i_pkt_chk (
            .phys_port_clk_ifc ( phys_port_clk_ifc ),
            .rst_n             ( rst_n             ),
            .rx_beat           ( rx_beat[p]        ),
            .rx_valid          ( rx_valid[p]       ),
            .head_len          ( head_len          ),
            .empty             ( empty             ),
            .pop               ( pop               ),
            .clear             ( clear[p]          ),
            .rx_frame_cnt      ( rx_frame_cnt[p]   ),
            .rx_err_cnt        ( rx_err_cnt[p]     )
        );

    end

endmodule

// File: rtl/pkt_gen.sv
/* Per-port packet generator */

`timescale 1ns/1ps

module pkt_gen import pkt_ex_pkg::*; (
    input  logic  phys_port_clk_ifc,
    input  logic  rst_n,

    // Four-phase request
    input  logic  req,
    input  blen_t len,
    output logic  ack,

    // Transmit stream
    output beat_t tx_beat,
    output logic  tx_valid,
    input  logic  tx_ready,

    // Length FIFO write side
    output logic  push,
    output blen_t push_len,
    input  logic  full,

    // Counter control
    input  logic  enable,
    input  logic  clear,
    output cnt_t  tx_frame_cnt
);

    gen_state_t state;

    // Bytes still to send and index of the next byte
    blen_t rem;
    blen_t idx;

    logic  xfer;
    logic  last_xfer;
    data_t word;
    keep_t last_keep;

    //////////////////////////////
    // Beat construction

    always_comb begin
        word = '0;
        for (int k = 0; k < BYTES_PER_WORD; k++) begin
            word[8*k +: 8] = idx[7:0] + 8'(k);
        end
    end

    // Lowest (rem mod 4) bytes on a short last word
    always_comb begin
        case (rem[1:0])
            2'd1:    last_keep = 4'b0001;
            2'd2:    last_keep = 4'b0011;
            2'd3:    last_keep = 4'b0111;
            default: last_keep = 4'b1111;
        endcase
    end

    assign tx_beat.last = (rem <= blen_t'(BYTES_PER_WORD));
    assign tx_beat.keep = tx_beat.last ? last_keep : '1;
    assign tx_beat.data = word;

    assign tx_valid  = (state == SEND);
    assign ack       = (state != IDLE);
    assign xfer      = tx_valid && tx_ready;
    assign last_xfer = xfer && tx_beat.last;

    // Length is recorded in the same cycle the request is taken
    assign push     = (state == IDLE) && req && !full;
    assign push_len = len;

    //////////////////////////////
    // FSM

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            rem   <= '0;
            idx   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (push) begin
                        state <= SEND;
                        rem   <= len;
                        idx   <= '0;
                    end
                end
                SEND: begin
                    if (xfer) begin
                        rem <= rem - blen_t'(BYTES_PER_WORD);
                        idx <= idx + blen_t'(BYTES_PER_WORD);
                    end
                    // Hold ack until the requester lets go
                    if (last_xfer) begin
                        state <= req ? DONE : IDLE;
                    end
                end
                DONE: begin
                    if (!req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Transmit frame counter

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            tx_frame_cnt <= '0;
        end else if (clear) begin
            tx_frame_cnt <= '0;
        end else if (enable && last_xfer) begin
            tx_frame_cnt <= tx_frame_cnt + 1'b1;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the packet exerciser testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_pkt_exerciser -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

# Keep running past assertion errors so the testbench gives its verdict
./obj_dir/sim_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    exit 0
fi
exit 1

// File: tb.f
rtl/pkt_ex_pkg.sv
rtl/pkt_gen.sv
rtl/len_fifo.sv
rtl/pkt_chk.sv
rtl/pkt_exerciser_top.sv
test/pkt_exerciser_assert.sv
test/tb_pkt_exerciser.sv

// File: test/pkt_exerciser_assert.sv
/* Handshake and stream assertions */

`timescale 1ns/1ps

module pkt_exerciser_assert import pkt_ex_pkg::*; #(
    parameter int NUM_PORTS = 2
) (
    input  logic                 phys_port_clk_ifc,
    input  logic                 rst_n,
    input  logic [NUM_PORTS-1:0] req,
    input  logic [NUM_PORTS-1:0] ack,
    input  beat_t                tx_beat [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] tx_valid,
    input  logic [NUM_PORTS-1:0] tx_ready
);

    // Failed assertions, read back by the testbench
    int fail_cnt = 0;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port

        // req was already low on the clock that dropped ack
        ack_fall_after_req: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
            $fell(ack[p]) |-> !$past(req[p])) else begin
            $error("port %0d ack fell while req was high", p);
            fail_cnt++;
        end

        beat_hold_on_stall: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
            tx_valid[p] && !tx_ready[p] |=> tx_valid[p] && $stable(tx_beat[p])) else begin
            $error("port %0d tx beat changed under a stall", p);
            fail_cnt++;
        end

        no_valid_without_ack: assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
            !ack[p] |-> !tx_valid[p]) else begin
            $error("port %0d tx_valid high while ack low", p);
            fail_cnt++;
        end

    end

endmodule

// File: test/tb_pkt_exerciser.sv
/* Packet exerciser testbench */

`timescale 1ns/1ps

module tb_pkt_exerciser import pkt_ex_pkg::*; ();

    localparam int NUM_PORTS     = 2;
    localparam int PKTS_PER_PORT = 12;
    localparam int MAX_CYCLES    = NUM_PORTS * PKTS_PER_PORT * (MTU_BYTES / 4 + 20) * 3;

    // Clocks req stays up after ack, longer than a short packet
    localparam int REQ_HOLD      = 3;

    logic                 phys_port_clk_ifc = 1'b0;
    logic                 rst_n;
    logic [NUM_PORTS-1:0] req;
    logic [NUM_PORTS-1:0] ack;
    logic [NUM_PORTS-1:0] tx_valid;
    logic [NUM_PORTS-1:0] enable;
    logic [NUM_PORTS-1:0] clear;
    logic [NUM_PORTS-1:0] tx_ready = '0;
    logic [NUM_PORTS-1:0] rx_valid = '0;
    blen_t                len [NUM_PORTS];
    beat_t                tx_beat [NUM_PORTS];
    beat_t                rx_beat [NUM_PORTS] = '{default: '0};
    cnt_t                 tx_frame_cnt [NUM_PORTS];
    cnt_t                 rx_frame_cnt [NUM_PORTS];
    cnt_t                 rx_err_cnt [NUM_PORTS];

    // Loopback and monitor state
    logic [NUM_PORTS-1:0] pend_valid = '0;
    beat_t                pend_beat [NUM_PORTS] = '{default: '0};
    logic                 stall_on;
    int                   corrupt_at [NUM_PORTS];
    int                   beats_seen [NUM_PORTS] = '{default: 0};
    int                   mon_idx [NUM_PORTS] = '{default: 0};
    int                   mon_len [NUM_PORTS];

    int exp_tx [NUM_PORTS];
    int exp_rx [NUM_PORTS];
    int exp_err [NUM_PORTS];
    int errors;
    int cycles;

    always #20 phys_port_clk_ifc = ~phys_port_clk_ifc;

    pkt_exerciser_top #(
        .NUM_PORTS ( NUM_PORTS )
    ) i_pkt_exerciser_top (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst_n             ( rst_n             ),
        .req               ( req               ),
        .len               ( len               ),
        .ack               ( ack               ),
        .tx_beat           ( tx_beat           ),
        .tx_valid          ( tx_valid          ),
        .tx_ready          ( tx_ready          ),
        .rx_beat           ( rx_beat           ),
        .rx_valid          ( rx_valid          ),
        .enable            ( enable            ),
        .clear             ( clear             ),
        .tx_frame_cnt      ( tx_frame_cnt      ),
        .rx_frame_cnt      ( rx_frame_cnt      ),
        .rx_err_cnt        ( rx_err_cnt        )
    );

    bind pkt_exerciser_top pkt_exerciser_assert #(
        .NUM_PORTS ( NUM_PORTS )
    ) i_pkt_exerciser_assert (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst_n             ( rst_n             ),
        .req               ( req               ),
        .ack               ( ack               ),
        .tx_beat           ( tx_beat           ),
        .tx_valid          ( tx_valid          ),
        .tx_ready          ( tx_ready          )
    );

    //////////////////////////////
    // Checks

    task automatic report_mismatch(input string msg);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    // Expected keep, last and bytes from the running byte index
    task automatic check_beat(input int p, input beat_t b);
        keep_t exp_keep;
        data_t exp_data;
        data_t en_mask;
        int    rem;
        rem      = mon_len[p] - mon_idx[p];
        exp_keep = '0;
        exp_data = '0;
        en_mask  = '0;
        for (int k = 0; k < BYTES_PER_WORD; k++) begin
            if (k < rem) begin
                exp_keep[k]        = 1'b1;
                en_mask[8*k +: 8]  = 8'hff;
                exp_data[8*k +: 8] = 8'((mon_idx[p] + k) % 256);
            end
        end
        assert (b.keep == exp_keep && b.last == (rem <= BYTES_PER_WORD)) else
            report_mismatch($sformatf("port %0d byte %0d keep %h last %b, expected keep %h",
                p, mon_idx[p], b.keep, b.last, exp_keep));
        assert ((b.data & en_mask) == exp_data) else
            report_mismatch($sformatf("port %0d byte %0d data %h, expected %h",
                p, mon_idx[p], b.data & en_mask, exp_data));
        mon_idx[p] = b.last ? 0 : mon_idx[p] + BYTES_PER_WORD;
    endtask

    task automatic check_counts(input int p);
        assert (tx_frame_cnt[p] == cnt_t'(exp_tx[p])) else
            report_mismatch($sformatf("port %0d tx_frame_cnt %0d, expected %0d",
                p, tx_frame_cnt[p], exp_tx[p]));
        assert (rx_frame_cnt[p] == cnt_t'(exp_rx[p])) else
            report_mismatch($sformatf("port %0d rx_frame_cnt %0d, expected %0d",
                p, rx_frame_cnt[p], exp_rx[p]));
        assert (rx_err_cnt[p] == cnt_t'(exp_err[p])) else
            report_mismatch($sformatf("port %0d rx_err_cnt %0d, expected %0d",
                p, rx_err_cnt[p], exp_err[p]));
    endtask

    //////////////////////////////
    // Stimulus

    function automatic int rand_len();
        return 64 + int'($urandom % (MTU_BYTES - 63));
    endfunction

    task automatic send_pkt(input int p, input int l, input logic bad);
        int first;
        assert (!ack[p]) else
            report_mismatch($sformatf("port %0d ack high before req", p));
        first         = beats_seen[p];
        mon_len[p]    = l;
        corrupt_at[p] = bad ? first : -1;
        len[p]        = blen_t'(l);
        req[p]        = 1'b1;
        do @(negedge phys_port_clk_ifc); while (!ack[p]);
        // Short packets finish while req is still up
        repeat (REQ_HOLD) @(negedge phys_port_clk_ifc);
        req[p] = 1'b0;
        do @(negedge phys_port_clk_ifc); while (ack[p]);
        // ack low means every beat of the packet has gone out
        assert (beats_seen[p] - first == (l + BYTES_PER_WORD - 1) / BYTES_PER_WORD) else
            report_mismatch($sformatf("port %0d length %0d sent %0d beats before ack fell",
                p, l, beats_seen[p] - first));
        if (enable[p]) begin
            exp_tx[p]++;
        end
        if (bad) begin
            exp_err[p]++;
        end else begin
            exp_rx[p]++;
        end
    endtask

    task automatic basic_lengths(input int p);
        send_pkt(p, 1, 1'b0);
        send_pkt(p, 4, 1'b0);
        send_pkt(p, 5, 1'b0);
        send_pkt(p, rand_len(), 1'b0);
    endtask

    task automatic random_packets(input int p, input int n);
        for (int i = 0; i < n; i++) begin
            send_pkt(p, rand_len(), 1'b0);
        end
    endtask

    // Loopback and checker each take one clock
    task automatic drain_and_check();
        repeat (3) @(negedge phys_port_clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_counts(p);
        end
    endtask

    //////////////////////////////
    // Loopback

    always @(negedge phys_port_clk_ifc) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            rx_valid[p]   = pend_valid[p];
            rx_beat[p]    = pend_beat[p];
            tx_ready[p]   = stall_on ? (($urandom % 4) != 0) : 1'b1;
            pend_valid[p] = tx_valid[p] && tx_ready[p];
            pend_beat[p]  = tx_beat[p];
            if (pend_valid[p]) begin
                check_beat(p, tx_beat[p]);
                if (beats_seen[p] == corrupt_at[p]) begin
                    pend_beat[p].data[7:0] = ~pend_beat[p].data[7:0];
                end
                beats_seen[p]++;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge phys_port_clk_ifc);
            cycles++;
        end
        $display("Timeout after %0d cycles, the packets did not complete", cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(86));
        errors   = 0;
        rst_n    = 1'b0;
        req      = '0;
        enable   = '1;
        clear    = '0;
        stall_on = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            len[p]        = '0;
            mon_len[p]    = 0;
            corrupt_at[p] = -1;
            exp_tx[p]     = 0;
            exp_rx[p]     = 0;
            exp_err[p]    = 0;
        end
        repeat (8) @(negedge phys_port_clk_ifc);
        rst_n = 1'b1;
        @(negedge phys_port_clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (!ack[p] && !tx_valid[p]) else
                report_mismatch($sformatf("port %0d ack or tx_valid high after reset", p));
            check_counts(p);
        end

        // Short, exact and partial-word lengths
        fork
            basic_lengths(0);
            basic_lengths(1);
        join
        drain_and_check();

        stall_on = 1'b1;
        fork
            random_packets(0, 6);
            random_packets(1, 6);
        join
        drain_and_check();

        // One flipped byte on port 0
        fork
            send_pkt(0, rand_len(), 1'b1);
            send_pkt(1, rand_len(), 1'b0);
        join
        drain_and_check();

        // Port 0 counting off, port 1 takes a flipped byte
        enable[0] = 1'b0;
        fork
            send_pkt(0, rand_len(), 1'b0);
            send_pkt(1, rand_len(), 1'b1);
        join
        drain_and_check();

        clear = '1;
        @(negedge phys_port_clk_ifc);
        clear = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_tx[p]  = 0;
            exp_rx[p]  = 0;
            exp_err[p] = 0;
            check_counts(p);
        end

        $display("Checks done: %0d check errors, %0d assertion failures",
            errors, i_pkt_exerciser_top.i_pkt_exerciser_assert.fail_cnt);
        if (errors == 0 && i_pkt_exerciser_top.i_pkt_exerciser_assert.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
